/* Makefile */
# Verilator build and run for the Thor decode unit testbench

VERILATOR  ?= verilator
TOP        ?= thor_decode_tb
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
PASS_TEXT  ?= Simulation finished: PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) verilog/*.sv bench/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/decode_patterns.mem */
// Columns: instr, prefix flag, regs {Ra Rb Rc Rt}, flags, imm, jmptgt
// Flag nibbles: rfwr ld ldz st memsz jmp jxx mul div csr multi_cycle flowchg
00420C4102 0 02030401 100030000000 0000000000000000 0000000000000108 // R2 ADD
00601CC502 0 06070005 100030010010 0000000000000000 0000000000000180 // R2 MUL
0070042102 0 01010001 100030001010 0000000000000000 00000000000001C0 // R2 DIV
00048C8304 0 04030903 100030000000 0000000000000123 0000000000000012 // ADDI positive
FFFFC00204 0 00101F02 100030000000 FFFFFFFFFFFFFFF0 FFFFFFFFFFFFFFFE // ADDI negative
0003FC2108 0 011F0701 100030000000 FFFFFFFFFFC000FF 000000000000000E // ANDI
8000000409 0 00000004 100030000000 0000000000200000 FFFFFFFFFFFE0000 // ORI
FFFFF04780 0 021C1F07 110000000010 FFFFFFFFFFFFFFFC FFFFFFFFFFFFFFFE // LDB negative
0000406181 0 03100001 111000000010 0000000000000010 0000000000000000 // LDBU
0000202282 0 01080002 110010000010 0000000000000008 0000000000000000 // LDW
0000804993 0 02000900 000130000010 0000000000000020 0000000000000002 // STO
0000002390 0 01000300 000100000010 0000000000000000 0000000000000000 // STB
0080000520 0 00000000 000031000001 0000000000000000 0000000000000200 // JMP
FFF8082026 0 01021000 000030100001 0000000000000000 FFFFFFFFFFFFFFE0 // JEQ back
000000240F 0 01000004 100030000100 0000000000000000 0000000000000000 // CSR
8000000151 1 00000000 000000000000 0000000000000000 0000000000000000 // EXI24
0000140104 0 00050001 100030000000 FFE0000000400005 0000000000000000 // ADDI extended
0000140104 0 00050001 100030000000 0000000000000005 0000000000000000 // ADDI plain
FFFFFFFF51 1 00000000 000000000000 0000000000000000 0000000000000000 // EXI24
0000000251 1 00000000 000000000000 0000000000000000 0000000000000000 // EXI24 replaces
0000040209 0 00010002 100030000000 0000000000800001 0000000000000000 // ORI extended
0000000000 0 00000000 000030000000 0000000000000000 0000000000000000 // NOP

/* bench/thor_decode_tb.sv */
`timescale 1ns/10ps
// Testbench for the Thor decode unit, pattern driven with a random-delay sink
module thor_decode_tb
	import thor_isa_pkg::*;
	import thor_decode_pkg::*;
();

	localparam int NUM_PAT     = 22;
	localparam int COLS        = 6;
	localparam int CYCLE_LIMIT = NUM_PAT * 20 + 100;

	logic    clk;
	logic    arst_n;
	logic    in_req;
	logic    in_ack;
	instr_t  in_instr;
	logic    out_req;
	logic    out_ack;
	decode_t out_deco;

	logic [63:0] pat_mem [0:NUM_PAT*COLS-1];
	int          exp_q[$];
	int          err_cnt [1:5];
	int          chk_cnt [1:5];
	string       test_name [1:5];
	int          exp_cnt;
	int          rx_cnt;
	int          out_cnt;
	logic        out_req_q;
	int          cycle_cnt;
	logic [15:0] lfsr;

	thor_decode_unit DUT (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_req   (in_req),
		.in_ack   (in_ack),
		.in_instr (in_instr),
		.out_req  (out_req),
		.out_ack  (out_ack),
		.out_deco (out_deco)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
		begin
			$display("timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// Output words as seen on out_req, apart from the sink
	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			out_req_q <= 1'b0;
			out_cnt   <= 0;
		end
		else
		begin
			out_req_q <= out_req;
			if (out_req && !out_req_q)
				out_cnt <= out_cnt + 1;
		end
	end

	// ============================================================
	// Helpers
	// ============================================================

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic pick_delay(output int d);
		int i;
		d = 0;
		for (i = 0; i < 3; i++)
		begin
			lfsr = lfsr_next(lfsr);
			d = (d << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic check_val(input int t, input string name,
		input logic [63:0] got, input logic [63:0] exp);
		chk_cnt[t]++;
		assert (got === exp)
		else
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			err_cnt[t]++;
		end
	endtask

	task automatic compare_output(input int idx);
		int          b;
		int          t_imm;
		logic [31:0] regs;
		logic [47:0] flags;
		b     = idx * COLS;
		regs  = pat_mem[b+2][31:0];
		flags = pat_mem[b+3][47:0];
		// Words right after a prefix belong to the extension test
		t_imm = 2;
		if (idx >= 1 && pat_mem[b-COLS+1][0])
			t_imm = 3;
		else if (idx >= 2 && pat_mem[b-2*COLS+1][0])
			t_imm = 3;
		check_val(1, "Ra", 64'(out_deco.Ra), 64'(regs[31:24]));
		check_val(1, "Rb", 64'(out_deco.Rb), 64'(regs[23:16]));
		check_val(1, "Rc", 64'(out_deco.Rc), 64'(regs[15:8]));
		check_val(1, "Rt", 64'(out_deco.Rt), 64'(regs[7:0]));
		check_val(1, "rfwr", 64'(out_deco.rfwr), 64'(flags[47:44]));
		check_val(t_imm, "imm", out_deco.imm, pat_mem[b+4]);
		check_val(4, "ld", 64'(out_deco.ld), 64'(flags[43:40]));
		check_val(4, "ldz", 64'(out_deco.ldz), 64'(flags[39:36]));
		check_val(4, "st", 64'(out_deco.st), 64'(flags[35:32]));
		check_val(4, "memsz", 64'(out_deco.memsz), 64'(flags[31:28]));
		check_val(4, "jmp", 64'(out_deco.jmp), 64'(flags[27:24]));
		check_val(4, "jxx", 64'(out_deco.jxx), 64'(flags[23:20]));
		check_val(4, "mul", 64'(out_deco.mul), 64'(flags[19:16]));
		check_val(4, "div", 64'(out_deco.div), 64'(flags[15:12]));
		check_val(4, "csr", 64'(out_deco.csr), 64'(flags[11:8]));
		check_val(4, "multi_cycle", 64'(out_deco.multi_cycle), 64'(flags[7:4]));
		check_val(4, "flowchg", 64'(out_deco.flowchg), 64'(flags[3:0]));
		check_val(4, "jmptgt", out_deco.jmptgt, pat_mem[b+5]);
	endtask

	// ============================================================
	// Source and sink
	// ============================================================
	task automatic run_source();
		int i;
		for (i = 0; i < NUM_PAT; i++)
		begin
			@(posedge clk);
			in_req   <= 1'b1;
			in_instr <= instr_t'(pat_mem[i*COLS][39:0]);
			do @(negedge clk); while (!in_ack);
			@(posedge clk);
			in_req <= 1'b0;
			do @(negedge clk); while (in_ack);
		end
	endtask

	task automatic run_sink();
		int d;
		int k;
		int idx;
		while (rx_cnt < exp_cnt)
		begin
			do @(negedge clk); while (!out_req);
			pick_delay(d);
			for (k = 0; k < d; k++)
				@(negedge clk);
			idx = exp_q.pop_front();
			compare_output(idx);
			rx_cnt++;
			@(posedge clk);
			out_ack <= 1'b1;
			do @(negedge clk); while (out_req);
			@(posedge clk);
			out_ack <= 1'b0;
		end
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial
	begin
		int i;
		int total_err;
		int total_chk;
		clk       = 1'b0;
		arst_n    = 1'b0;
		in_req    = 1'b0;
		in_instr  = '0;
		out_ack   = 1'b0;
		lfsr      = 16'd17560;
		exp_cnt   = 0;
		rx_cnt    = 0;
		cycle_cnt = 0;
		for (i = 1; i <= 5; i++)
		begin
			err_cnt[i] = 0;
			chk_cnt[i] = 0;
		end
		test_name[1] = "register fields";
		test_name[2] = "immediate extension";
		test_name[3] = "prefix merge";
		test_name[4] = "class flags";
		test_name[5] = "ordering and count";

		$readmemh("bench/decode_patterns.mem", pat_mem);
		for (i = 0; i < NUM_PAT; i++)
		begin
			if (!pat_mem[i*COLS+1][0])
			begin
				exp_q.push_back(i);
				exp_cnt++;
			end
		end

		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_val(5, "in_ack", 64'(in_ack), 64'd0);
		check_val(5, "out_req", 64'(out_req), 64'd0);

		fork
			run_source();
			run_sink();
		join

		// Prefix words must not leave a trailing output
		repeat (20)
		begin
			@(negedge clk);
			assert (!out_req)
			else
			begin
				$display("unexpected extra output word at %0t", $time);
				err_cnt[5]++;
			end
		end
		check_val(5, "output count", 64'(out_cnt), 64'(exp_cnt));

		total_err = 0;
		total_chk = 0;
		for (i = 1; i <= 5; i++)
		begin
			$display("test %0d %s: %0d checks, %0d errors, %s", i, test_name[i],
				chk_cnt[i], err_cnt[i], (err_cnt[i] == 0) ? "ok" : "failed");
			total_err += err_cnt[i];
			total_chk += chk_cnt[i];
		end
		$display("words out %0d of %0d, checks %0d, errors %0d",
			out_cnt, exp_cnt, total_chk, total_err);
		if (total_err == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* sim.f */
verilog/thor_isa_pkg.sv
verilog/thor_decode_pkg.sv
verilog/thor_hs_stage.sv
verilog/thor_prefix_tracker.sv
verilog/thor_decoder.sv
verilog/thor_decode_unit.sv
bench/thor_decode_tb.sv

/* verilog/thor_decode_pkg.sv */
// Thor decode-stage types for the prefix extension, fetch payload and decoded instruction
package thor_decode_pkg;

	import thor_isa_pkg::*;

	// Memory access size
	typedef enum logic [1:0] {
		byt  = 2'd0,
		wyde = 2'd1,
		octa = 2'd3
	} memsz_e;

	// Pending EXI24 payload, bits 39:8 of the prefix word
	typedef struct packed {
		logic        valid;
		logic [31:0] payload;
	} ext_t;

	// Instruction paired with the extension that preceded it
	typedef struct packed {
		instr_t instr;
		ext_t   ext;
	} fetch_t;

	// ============================================================
	// Decoder output
	// ============================================================
	typedef struct packed {
		logic [4:0] Ra;
		logic [4:0] Rb;
		logic [4:0] Rc;
		logic [4:0] Rt;
		logic       rfwr;
		value_t     imm;
		logic       ld;
		logic       ldz;
		logic       st;
		memsz_e     memsz;
		logic       jmp;
		logic       jxx;
		value_t     jmptgt;
		logic       mul;
		logic       div;
		logic       csr;
		logic       multi_cycle;
		logic       flowchg;
	} decode_t;

endpackage

/* verilog/thor_decode_unit.sv */
`timescale 1ns/10ps
// Thor decode unit with input stage, prefix tracker, decoder and output stage on four-phase links
module thor_decode_unit
	import thor_isa_pkg::*;
	import thor_decode_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  logic    in_req,
	output logic    in_ack,
	input  instr_t  in_instr,
	output logic    out_req,
	input  logic    out_ack,
	output decode_t out_deco
);

	// Input stage to tracker
	logic    mid_req;
	logic    mid_ack;
	instr_t  mid_instr;

	// Tracker to output stage, through the decoder
	logic    dec_req;
	logic    dec_ack;
	fetch_t  dec_fetch;
	decode_t dec_deco;

	thor_hs_stage #(
		.payload_t (instr_t)
	) u_in_stage (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_req   (in_req),
		.in_ack   (in_ack),
		.in_data  (in_instr),
		.out_req  (mid_req),
		.out_ack  (mid_ack),
		.out_data (mid_instr)
	);

	thor_prefix_tracker u_tracker (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_req    (mid_req),
		.in_ack    (mid_ack),
		.in_instr  (mid_instr),
		.out_req   (dec_req),
		.out_ack   (dec_ack),
		.out_fetch (dec_fetch)
	);

	thor_decoder u_decoder (
		.fetch (dec_fetch),
		.deco  (dec_deco)
	);

	thor_hs_stage #(
		.payload_t (decode_t)
	) u_out_stage (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_req   (dec_req),
		.in_ack   (dec_ack),
		.in_data  (dec_deco),
		.out_req  (out_req),
		.out_ack  (out_ack),
		.out_data (out_deco)
	);

endmodule

/* verilog/thor_decoder.sv */
`timescale 1ns/10ps
// Thor instruction decoder producing register fields, immediate, memory and branch classes
module thor_decoder
	import thor_isa_pkg::*;
	import thor_decode_pkg::*;
(
	input  fetch_t  fetch,
	output decode_t deco
);

	instr_t      ir;
	func_e       func;
	logic [21:0] imm22;
	logic [16:0] tgt17;
	value_t      imm;

	assign ir    = fetch.instr;
	assign func  = instr_func(fetch.instr);
	assign imm22 = instr_imm22(fetch.instr);
	assign tgt17 = instr_tgt17(fetch.instr);

	always_comb
	begin
		// ============================================================
		// Register fields
		// ============================================================
		deco.Ra = ir.Ra;
		deco.Rb = ir.Rb;

		// Stores and branches have no target register
		case (ir.opcode)
		STB, STO, JMP, JEQ:
			deco.Rt = 5'd0;
		default:
			deco.Rt = ir.Rt;
		endcase

		// Store data sits in the Rt slot of the word
		case (ir.opcode)
		STB, STO:
			deco.Rc = ir.Rt;
		default:
			deco.Rc = ir.Rc;
		endcase

		case (ir.opcode)
		R2, ADDI, ANDI, ORI, MULI, DIVI, CSR:
			deco.rfwr = 1'b1;
		LDB, LDBU, LDW, LDO:
			deco.rfwr = 1'b1;
		default:
			deco.rfwr = 1'b0;
		endcase

		// ============================================================
		// Immediate
		// ============================================================
		case (ir.opcode)
		ADDI, MULI, DIVI, LDB, LDBU, LDW, LDO, STB, STO:
			imm = {{42{imm22[21]}}, imm22};
		// Pad with ones so the mask keeps the upper bits
		ANDI:
			imm = {{42{1'b1}}, imm22};
		ORI:
			imm = {42'd0, imm22};
		default:
			imm = '0;
		endcase
		// Prefix payload replaces everything above the low 22 bits
		if (fetch.ext.valid)
			imm = {{10{fetch.ext.payload[31]}}, fetch.ext.payload, imm[21:0]};
		deco.imm = imm;

		// ============================================================
		// Memory class
		// ============================================================
		case (ir.opcode)
		LDB, LDBU, LDW, LDO:
			deco.ld = 1'b1;
		default:
			deco.ld = 1'b0;
		endcase

		deco.ldz = (ir.opcode == LDBU);

		case (ir.opcode)
		STB, STO:
			deco.st = 1'b1;
		default:
			deco.st = 1'b0;
		endcase

		case (ir.opcode)
		LDB, LDBU, STB:
			deco.memsz = byt;
		LDW:
			deco.memsz = wyde;
		default:
			deco.memsz = octa;
		endcase

		// Branches
		deco.jmp    = (ir.opcode == JMP);
		deco.jxx    = (ir.opcode == JEQ);
		deco.jmptgt = {{46{tgt17[16]}}, tgt17, 1'b0};

		// Multiply and divide, immediate or register form
		case (ir.opcode)
		R2:
			deco.mul = (func == MUL);
		MULI:
			deco.mul = 1'b1;
		default:
			deco.mul = 1'b0;
		endcase

		case (ir.opcode)
		R2:
			deco.div = (func == DIV);
		DIVI:
			deco.div = 1'b1;
		default:
			deco.div = 1'b0;
		endcase

		deco.csr         = (ir.opcode == CSR);
		deco.multi_cycle = deco.mul | deco.div | deco.ld | deco.st;
		deco.flowchg     = deco.jmp | deco.jxx;
	end

	// Load and store tables are kept separately
	always_comb
	begin
		assert (!(deco.ld && deco.st))
		else $error("decoder: load and store both set for opcode %h", ir.opcode);
	end

endmodule

/* verilog/thor_hs_stage.sv */
`timescale 1ns/10ps
// Four-phase holding stage with one entry of any payload between two req/ack links
module thor_hs_stage #(
	parameter type payload_t = logic [39:0]
)(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_req,
	output logic     in_ack,
	input  payload_t in_data,
	output logic     out_req,
	input  logic     out_ack,
	output payload_t out_data
);

	typedef enum logic [1:0] {S_EMPTY, S_ACK, S_FULL, S_WAIT} state_e;

	state_e state;
	logic   capture;

	// Take a new word only when empty and the previous upstream cycle has closed
	assign capture = (state == S_EMPTY) && in_req && !in_ack;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= S_EMPTY;
			in_ack  <= 1'b0;
			out_req <= 1'b0;
		end
		else
		begin
			// Upstream side runs on its own once the word is held
			if (capture)
				in_ack <= 1'b1;
			else if (in_ack && !in_req)
				in_ack <= 1'b0;

			case (state)
			S_EMPTY:
				if (capture)
					state <= S_ACK;
			S_ACK:
			begin
				out_req <= 1'b1;
				state   <= S_FULL;
			end
			S_FULL:
				if (out_ack)
				begin
					out_req <= 1'b0;
					state   <= S_WAIT;
				end
			S_WAIT:
				if (!out_ack)
					state <= S_EMPTY;
			default:
				state <= S_EMPTY;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
			out_data <= in_data;
	end

	// ============================================================
	// Downstream protocol checks
	// ============================================================
	a_data_held: assert property (@(posedge clk) disable iff (!arst_n)
		out_req && !out_ack |=> $stable(out_data))
		else $error("hs_stage: out_data changed while awaiting out_ack");

	a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(out_req) |-> $past(out_ack))
		else $error("hs_stage: out_req dropped before out_ack");

endmodule

/* verilog/thor_isa_pkg.sv */
// Thor ISA definitions covering the instruction word layout, opcodes and R2 function codes
package thor_isa_pkg;

	// ============================================================
	// Operand and opcode encodings
	// ============================================================

	// General register and immediate width
	typedef logic [63:0] value_t;

	// Major opcodes, bits 7:0 of every instruction
	typedef enum logic [7:0] {
		NOP   = 8'h00,
		R2    = 8'h02,
		ADDI  = 8'h04,
		MULI  = 8'h06,
		DIVI  = 8'h07,
		ANDI  = 8'h08,
		ORI   = 8'h09,
		CSR   = 8'h0F,
		JMP   = 8'h20,
		JEQ   = 8'h26,
		EXI24 = 8'h51,
		LDB   = 8'h80,
		LDBU  = 8'h81,
		LDW   = 8'h82,
		LDO   = 8'h86,
		STB   = 8'h90,
		STO   = 8'h93
	} opcode_e;

	// R2 function field, bits 33:28
	typedef enum logic [5:0] {
		ADD = 6'h04,
		MUL = 6'h06,
		DIV = 6'h07,
		AND = 6'h08
	} func_e;

	// ============================================================
	// Instruction word
	// ============================================================

	// The upper 12 bits are shared by several formats
	// R2 puts func in the low six, immediates run from bit 18 up,
	// branches take their target from bit 23 up
	typedef struct packed {
		logic [11:0] upper;
		logic [4:0]  Rc;
		logic [4:0]  Rb;
		logic [4:0]  Ra;
		logic [4:0]  Rt;
		opcode_e     opcode;
	} instr_t;

	// R2 function code, bits 33:28
	function automatic func_e instr_func(instr_t ir);
		return func_e'(ir.upper[5:0]);
	endfunction

	// Immediate field, bits 39:18
	function automatic logic [21:0] instr_imm22(instr_t ir);
		return {ir.upper, ir.Rc, ir.Rb};
	endfunction

	// Branch target field, bits 39:23
	function automatic logic [16:0] instr_tgt17(instr_t ir);
		return {ir.upper, ir.Rc};
	endfunction

endpackage

/* verilog/thor_prefix_tracker.sv */
`timescale 1ns/10ps
// Prefix tracker that absorbs EXI24 words and pairs their payload with the next instruction
module thor_prefix_tracker
	import thor_isa_pkg::*;
	import thor_decode_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  logic   in_req,
	output logic   in_ack,
	input  instr_t in_instr,
	output logic   out_req,
	input  logic   out_ack,
	output fetch_t out_fetch
);

	typedef enum logic [1:0] {T_IDLE, T_FWD, T_REL} state_e;

	state_e state;
	ext_t   ext;
	logic   is_prefix;

	assign is_prefix = (in_instr.opcode == EXI24);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= T_IDLE;
			in_ack  <= 1'b0;
			out_req <= 1'b0;
			ext     <= '0;
		end
		else
		begin
			case (state)
			T_IDLE:
				if (in_req)
				begin
					if (is_prefix)
					begin
						// Latest prefix wins
						ext.valid   <= 1'b1;
						ext.payload <= in_instr[39:8];
						in_ack      <= 1'b1;
						state       <= T_REL;
					end
					else
					begin
						out_req <= 1'b1;
						state   <= T_FWD;
					end
				end
			// Upstream ack waits for the downstream capture
			T_FWD:
				if (out_ack)
				begin
					out_req   <= 1'b0;
					in_ack    <= 1'b1;
					ext.valid <= 1'b0;
					state     <= T_REL;
				end
			// Both links must return to zero
			T_REL:
				if (!in_req && !out_ack)
				begin
					in_ack <= 1'b0;
					state  <= T_IDLE;
				end
			default:
				state <= T_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == T_IDLE && in_req && !is_prefix)
			out_fetch <= '{instr: in_instr, ext: ext};
	end

	a_no_prefix_out: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(out_req) |-> out_fetch.instr.opcode != EXI24)
		else $error("prefix_tracker: EXI24 word forwarded downstream");

endmodule
